//--- hdl/alu_pkg.sv
package alu_pkg;

  localparam int data_w = 32;
  localparam int reg_aw = 4;
  localparam int nregs  = 1 << reg_aw;

  typedef enum logic [2:0] {
    op_add   = 3'd0,
    op_sub   = 3'd1,
    op_and   = 3'd2,
    op_or    = 3'd3,
    op_xor   = 3'd4,
    op_addi  = 3'd5,
    op_shift = 3'd6
  } op_e;

  // shift view of the 16-bit operand field.
  typedef struct packed {
    logic [4:0] amount;
    logic       dir;      // 1 = right.
    logic       arith;    // right shifts only.
    logic [8:0] pad;
  } shift_ctl_t;

  // op_addi reads imm, op_shift reads shf.
  typedef union packed {
    logic signed [15:0] imm;
    shift_ctl_t         shf;
  } operand_u;

  typedef struct packed {
    logic              valid;
    op_e               op;
    logic [reg_aw-1:0] rt;
    logic [reg_aw-1:0] ra;
    logic [reg_aw-1:0] rb;
    operand_u          fld;
  } alu_op_t;

  typedef struct packed {
    alu_op_t lane0;
    alu_op_t lane1;
  } bundle_t;

  typedef struct packed {
    logic [data_w-1:0] res0;
    logic [data_w-1:0] res1;
    logic [reg_aw-1:0] rt0;
    logic [reg_aw-1:0] rt1;
    logic              v0;
    logic              v1;
    logic              split;   // bundle took two steps.
    logic              tag;     // alternates per bundle.
  } completion_t;

endpackage

//--- hdl/issue_rx.sv
`timescale 1ns/1ps

module issue_rx (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             in_req,
  input  alu_pkg::bundle_t in_bundle,
  output logic             in_ack,
  output logic             bun_valid,
  output alu_pkg::bundle_t bun,
  input  logic             bun_take
);

  typedef enum logic [1:0] {
    st_idle,
    st_acked,
    st_wait_low
  } rx_state_e;

  rx_state_e state;
  logic      latch;

  // accept only into an empty holding register.
  assign latch = (state == st_idle) && in_req && !bun_valid;

  assign in_ack = (state != st_idle);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (latch) state <= st_acked;
        end
        st_acked: begin
          if (!in_req) state <= st_idle;
          else state <= st_wait_low;
        end
        st_wait_low: begin
          if (!in_req) state <= st_idle;   // source released, drop ack.
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bun_valid <= 1'b0;
    end else if (latch) begin
      bun_valid <= 1'b1;
    end else if (bun_take) begin
      bun_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (latch) bun <= in_bundle;
  end

endmodule

//--- hdl/alu_regfile.sv
`timescale 1ns/1ps

module alu_regfile (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [alu_pkg::reg_aw-1:0] ra0,
  input  logic [alu_pkg::reg_aw-1:0] rb0,
  input  logic [alu_pkg::reg_aw-1:0] ra1,
  input  logic [alu_pkg::reg_aw-1:0] rb1,
  output logic [alu_pkg::data_w-1:0] rd_a0,
  output logic [alu_pkg::data_w-1:0] rd_b0,
  output logic [alu_pkg::data_w-1:0] rd_a1,
  output logic [alu_pkg::data_w-1:0] rd_b1,
  input  logic                       we0,
  input  logic                       we1,
  input  logic [alu_pkg::reg_aw-1:0] wa0,
  input  logic [alu_pkg::reg_aw-1:0] wa1,
  input  logic [alu_pkg::data_w-1:0] wd0,
  input  logic [alu_pkg::data_w-1:0] wd1
);
  import alu_pkg::*;

  logic [data_w-1:0] mem [nregs];

  // reads are combinational.
  assign rd_a0 = mem[ra0];
  assign rd_b0 = mem[rb0];
  assign rd_a1 = mem[ra1];
  assign rd_b1 = mem[rb1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < nregs; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (we0) mem[wa0] <= wd0;
      if (we1) mem[wa1] <= wd1;   // later write wins on same address.
    end
  end

endmodule

//--- hdl/alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       bun_valid,
  input  alu_pkg::bundle_t           bun,
  output logic                       bun_take,
  output logic [alu_pkg::reg_aw-1:0] ra0,
  output logic [alu_pkg::reg_aw-1:0] rb0,
  output logic [alu_pkg::reg_aw-1:0] ra1,
  output logic [alu_pkg::reg_aw-1:0] rb1,
  input  logic [alu_pkg::data_w-1:0] rd_a0,
  input  logic [alu_pkg::data_w-1:0] rd_b0,
  input  logic [alu_pkg::data_w-1:0] rd_a1,
  input  logic [alu_pkg::data_w-1:0] rd_b1,
  output logic                       we0,
  output logic                       we1,
  output logic [alu_pkg::reg_aw-1:0] wa0,
  output logic [alu_pkg::reg_aw-1:0] wa1,
  output logic [alu_pkg::data_w-1:0] wd0,
  output logic [alu_pkg::data_w-1:0] wd1,
  output logic                       cmp_valid,
  output alu_pkg::completion_t       cmp,
  input  logic                       cmp_ready
);
  import alu_pkg::*;

  typedef enum logic {
    st_first,
    st_second
  } seq_e;

  seq_e              state;
  alu_op_t           l0;
  alu_op_t           l1;
  logic              dep_a;
  logic              dep_b;
  logic              dep;
  logic              go;
  logic              fire;
  logic [data_w-1:0] op_a1;
  logic [data_w-1:0] op_b1;
  logic [data_w-1:0] res0;
  logic [data_w-1:0] res1;
  logic [data_w-1:0] res0_q;
  logic              tag_q;

  function automatic logic [data_w-1:0] alu_calc(input alu_op_t o,
                                                  input logic [data_w-1:0] a,
                                                  input logic [data_w-1:0] b);
    logic signed [data_w-1:0] imm_x;
    logic [4:0]               amt;
    imm_x = o.fld.imm;   // sign-extends.
    amt   = o.fld.shf.amount;
    case (o.op)
      op_add:  alu_calc = a + b;
      op_sub:  alu_calc = a - b;
      op_and:  alu_calc = a & b;
      op_or:   alu_calc = a | b;
      op_xor:  alu_calc = a ^ b;
      op_addi: alu_calc = a + imm_x;
      op_shift: begin
        if (!o.fld.shf.dir) alu_calc = a << amt;
        else if (o.fld.shf.arith) alu_calc = $unsigned($signed(a) >>> amt);
        else alu_calc = a >> amt;
      end
      default: alu_calc = '0;
    endcase
  endfunction

  assign l0 = bun.lane0;
  assign l1 = bun.lane1;

  // rb is not an operand for addi and shift, fld takes its place.
  assign dep_a = l0.valid && l1.valid && (l1.ra == l0.rt);
  assign dep_b = l0.valid && l1.valid && (l1.rb == l0.rt) &&
                 (l1.op != op_addi) && (l1.op != op_shift);
  assign dep   = dep_a || dep_b;

  assign ra0 = l0.ra;
  assign rb0 = l0.rb;
  assign ra1 = l1.ra;
  assign rb1 = l1.rb;

  // bypass lane 0's registered result in the second step.
  assign op_a1 = (state == st_second && dep_a) ? res0_q : rd_a1;
  assign op_b1 = (state == st_second && dep_b) ? res0_q : rd_b1;

  assign res0 = alu_calc(l0, rd_a0, rd_b0);
  assign res1 = alu_calc(l1, op_a1, op_b1);

  assign go   = bun_valid && cmp_ready;
  assign fire = go && ((state == st_second) || !dep);

  assign we0 = go && (state == st_first) && l0.valid;
  assign wa0 = l0.rt;
  assign wd0 = res0;
  assign we1 = fire && l1.valid;
  assign wa1 = l1.rt;
  assign wd1 = res1;

  assign bun_take  = fire;
  assign cmp_valid = fire;

  always_comb begin
    cmp.res0  = (state == st_second) ? res0_q : res0;
    cmp.res1  = res1;
    cmp.rt0   = l0.rt;
    cmp.rt1   = l1.rt;
    cmp.v0    = l0.valid;
    cmp.v1    = l1.valid;
    cmp.split = (state == st_second);
    cmp.tag   = tag_q;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_first;
      tag_q <= 1'b0;
    end else begin
      if (fire) tag_q <= ~tag_q;
      case (state)
        st_first:  if (go && dep) state <= st_second;
        st_second: if (fire) state <= st_first;
        default:   state <= st_first;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_first) res0_q <= res0;
  end

endmodule

//--- hdl/wb_tx.sv
`timescale 1ns/1ps

module wb_tx (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cmp_valid,
  input  alu_pkg::completion_t cmp,
  output logic                 cmp_ready,
  output logic                 out_req,
  output alu_pkg::completion_t out_cmp,
  input  logic                 out_ack
);

  typedef enum logic [1:0] {
    st_empty,
    st_req,
    st_release
  } tx_state_e;

  tx_state_e state;

  assign cmp_ready = (state == st_empty);
  assign out_req   = (state == st_req);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_empty;
    end else begin
      case (state)
        st_empty: begin
          if (cmp_valid) state <= st_req;
        end
        st_req: begin
          if (out_ack) state <= st_release;   // sink has the record.
        end
        st_release: begin
          if (!out_ack) state <= st_empty;
        end
        default: state <= st_empty;
      endcase
    end
  end

  // record is held until the sink drops ack.
  always_ff @(posedge clk) begin
    if (cmp_valid && cmp_ready) out_cmp <= cmp;
  end

endmodule

//--- hdl/alu_cluster_top.sv
`timescale 1ns/1ps

module alu_cluster_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 in_req,
  input  alu_pkg::bundle_t     in_bundle,
  output logic                 in_ack,
  output logic                 out_req,
  output alu_pkg::completion_t out_cmp,
  input  logic                 out_ack
);
  import alu_pkg::*;

  bundle_t           bun;
  logic              bun_valid;
  logic              bun_take;
  completion_t       cmp;
  logic              cmp_valid;
  logic              cmp_ready;
  logic [reg_aw-1:0] ra0;
  logic [reg_aw-1:0] rb0;
  logic [reg_aw-1:0] ra1;
  logic [reg_aw-1:0] rb1;
  logic [data_w-1:0] rd_a0;
  logic [data_w-1:0] rd_b0;
  logic [data_w-1:0] rd_a1;
  logic [data_w-1:0] rd_b1;
  logic              we0;
  logic              we1;
  logic [reg_aw-1:0] wa0;
  logic [reg_aw-1:0] wa1;
  logic [data_w-1:0] wd0;
  logic [data_w-1:0] wd1;

  issue_rx u_issue_rx (
    .clk, .arst_n, .in_req, .in_bundle, .in_ack, .bun_valid, .bun, .bun_take
  );

  alu_regfile u_regfile (
    .clk, .arst_n, .ra0, .rb0, .ra1, .rb1, .rd_a0, .rd_b0, .rd_a1, .rd_b1,
    .we0, .we1, .wa0, .wa1, .wd0, .wd1
  );

  alu_exec u_exec (
    .clk, .arst_n, .bun_valid, .bun, .bun_take,
    .ra0, .rb0, .ra1, .rb1, .rd_a0, .rd_b0, .rd_a1, .rd_b1,
    .we0, .we1, .wa0, .wa1, .wd0, .wd1,
    .cmp_valid, .cmp, .cmp_ready
  );

  wb_tx u_wb_tx (
    .clk, .arst_n, .cmp_valid, .cmp, .cmp_ready, .out_req, .out_cmp, .out_ack
  );

endmodule

//--- sim/alu_cluster_properties.sv
`timescale 1ns/1ps

module alu_cluster_properties (
  input logic                 clk,
  input logic                 arst_n,
  input logic                 in_req,
  input logic                 in_ack,
  input logic                 out_req,
  input logic                 out_ack,
  input alu_pkg::completion_t out_cmp,
  input logic                 seq_second,
  input logic                 bun_valid,
  input logic                 cmp_valid
);

  int unsigned fail_count = 0;

  a_in_release: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(in_ack) |-> !$past(in_req))
    else begin
      fail_count++;
      $error("in_ack fell while in_req was still high");
    end

  // a new request only once the previous ack is gone.
  a_in_gap: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(in_req) |-> !$past(in_ack))
    else begin
      fail_count++;
      $error("in_req rose before in_ack returned low");
    end

  a_out_release: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(out_req) |-> $past(out_ack))
    else begin
      fail_count++;
      $error("out_req fell without out_ack");
    end

  a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
    out_req && $past(out_req) |-> $stable(out_cmp))
    else begin
      fail_count++;
      $error("out_cmp changed while out_req was high");
    end

  // second step of a split keeps the bundle and completes in that cycle.
  a_split_step: assert property (@(posedge clk) disable iff (!arst_n)
    seq_second |-> bun_valid && cmp_valid)
    else begin
      fail_count++;
      $error("split second step without its bundle or without completing");
    end

endmodule

bind alu_cluster_top alu_cluster_properties u_props (
  .clk, .arst_n, .in_req, .in_ack, .out_req, .out_ack, .out_cmp,
  .seq_second(cmp.split), .bun_valid, .cmp_valid
);

//--- sim/tb_alu_cluster.sv
`timescale 1ns/1ps

module tb_alu_cluster;
  import alu_pkg::*;

  localparam int n_seed    = 8;
  localparam int n_mix     = 6;
  localparam int n_rand    = 20;
  localparam int n_bundles = n_seed + n_mix + 2 + 2 + 10 + n_rand + 1;

  logic              clk;
  logic              arst_n;
  logic              in_req;
  bundle_t           in_bundle;
  logic              in_ack;
  logic              out_req;
  completion_t       out_cmp;
  logic              out_ack;
  logic [data_w-1:0] ref_regs [nregs];
  completion_t       exp_q [$];
  logic              exp_tag;
  int                seed = 32'h609f;

  alu_cluster_top DUT (
    .clk, .arst_n, .in_req, .in_bundle, .in_ack, .out_req, .out_cmp, .out_ack
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (200 * n_bundles) @(posedge clk);
    abort_run("watchdog expired, a handshake never completed");
  end

  initial begin
    wait (DUT.u_props.fail_count != 0);
    abort_run("a bound assertion failed");
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_word(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] want);
    if (got !== want) begin
      $display("Mismatch %s: got %h expected %h", name, got, want);
      abort_run("result check failed");
    end
  endtask

  task automatic compare_completion(input completion_t got, input completion_t want);
    if (want.v0) compare_word("out_cmp.res0", got.res0, want.res0);
    if (want.v1) compare_word("out_cmp.res1", got.res1, want.res1);
    compare_word("out_cmp.rt0", data_w'(got.rt0), data_w'(want.rt0));
    compare_word("out_cmp.rt1", data_w'(got.rt1), data_w'(want.rt1));
    compare_word("out_cmp.v0", data_w'(got.v0), data_w'(want.v0));
    compare_word("out_cmp.v1", data_w'(got.v1), data_w'(want.v1));
    compare_word("out_cmp.split", data_w'(got.split), data_w'(want.split));
    compare_word("out_cmp.tag", data_w'(got.tag), data_w'(want.tag));
  endtask

  function automatic logic [data_w-1:0] expected_result(input alu_op_t o,
      input logic [data_w-1:0] a, input logic [data_w-1:0] b);
    logic [data_w-1:0] ext;
    logic [data_w-1:0] fill;
    ext  = {{16{o.fld.imm[15]}}, o.fld.imm};
    fill = ~({data_w{1'b1}} >> o.fld.shf.amount);   // sign bits moved in from the top.
    case (o.op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_addi: return a + ext;
      op_shift: begin
        case ({o.fld.shf.dir, o.fld.shf.arith})
          2'b10:   return a >> o.fld.shf.amount;
          2'b11:   return (a >> o.fld.shf.amount) | (a[data_w-1] ? fill : '0);
          default: return a << o.fld.shf.amount;
        endcase
      end
      default: return '0;
    endcase
  endfunction

  // reference model where lane 1 sees lane 0's write as the split does.
  task automatic predict(input bundle_t b, output completion_t want);
    logic dep;
    dep = b.lane0.valid && b.lane1.valid && ((b.lane1.ra == b.lane0.rt) ||
          ((b.lane1.rb == b.lane0.rt) && b.lane1.op != op_addi && b.lane1.op != op_shift));
    want.res0 = expected_result(b.lane0, ref_regs[b.lane0.ra], ref_regs[b.lane0.rb]);
    if (b.lane0.valid) ref_regs[b.lane0.rt] = want.res0;
    want.res1 = expected_result(b.lane1, ref_regs[b.lane1.ra], ref_regs[b.lane1.rb]);
    if (b.lane1.valid) ref_regs[b.lane1.rt] = want.res1;
    want.rt0   = b.lane0.rt;
    want.rt1   = b.lane1.rt;
    want.v0    = b.lane0.valid;
    want.v1    = b.lane1.valid;
    want.split = dep;
    want.tag   = exp_tag;
    exp_tag    = ~exp_tag;
  endtask

  function automatic alu_op_t build_op(input op_e op, input logic [reg_aw-1:0] rt,
      input logic [reg_aw-1:0] ra, input logic [reg_aw-1:0] rb, input logic [15:0] fld);
    alu_op_t o;
    o.valid = 1'b1;
    o.op    = op;
    o.rt    = rt;
    o.ra    = ra;
    o.rb    = rb;
    o.fld   = fld;
    return o;
  endfunction

  // cases 0..11 walk amounts 0, 1, 31 for each dir/arith pair.
  function automatic logic [15:0] shift_case(input int j);
    shift_ctl_t s;
    int         combo;
    s        = '0;
    combo    = j / 3;
    s.amount = (j % 3 == 0) ? 5'd0 : (j % 3 == 1) ? 5'd1 : 5'd31;
    s.dir    = combo[1];
    s.arith  = combo[0];
    return s;
  endfunction

  function automatic alu_op_t random_op();
    alu_op_t    o;
    logic [2:0] code;
    o       = $random(seed);
    code    = 3'($unsigned($random(seed)) % 7);
    o.op    = op_e'(code);
    o.valid = ($random(seed) & 3) != 0;   // mostly valid.
    return o;
  endfunction

  task automatic send_bundle(input bundle_t b);
    completion_t want;
    predict(b, want);
    exp_q.push_back(want);
    @(posedge clk);
    in_bundle <= b;
    in_req    <= 1'b1;
    @(posedge clk);
    while (!in_ack) @(posedge clk);
    in_req <= 1'b0;
    @(posedge clk);
    while (in_ack) @(posedge clk);
  endtask

  task automatic get_completion(input int ack_delay, output completion_t got);
    @(posedge clk);
    while (!out_req) @(posedge clk);
    got = out_cmp;
    repeat (ack_delay) @(posedge clk);
    out_ack <= 1'b1;
    @(posedge clk);
    while (out_req) @(posedge clk);
    out_ack <= 1'b0;
    if (exp_q.size() == 0) abort_run("completion arrived with no bundle outstanding");
    compare_completion(got, exp_q.pop_front());
  endtask

  task automatic run_bundle(input bundle_t b, output completion_t got);
    send_bundle(b);
    get_completion(0, got);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    foreach (ref_regs[i]) ref_regs[i] = '0;
    exp_tag = 1'b0;
    exp_q.delete();
  endtask

  task automatic independent_lanes();
    alu_op_t     a;
    alu_op_t     b;
    completion_t c;
    for (int i = 0; i < n_seed; i++) begin
      a = build_op(op_addi, reg_aw'(2*i), reg_aw'(2*i), 4'd0, 16'($random(seed)));
      b = build_op(op_addi, reg_aw'(2*i+1), reg_aw'(2*i+1), 4'd0, 16'($random(seed)));
      run_bundle({a, b}, c);
    end
    for (int i = 0; i < n_mix; i++) begin
      a = build_op(op_e'(3'(i % 5)), 4'($random(seed)), 4'($random(seed)),
                   4'($random(seed)), '0);
      b = build_op(op_e'(3'((i + 2) % 5)), 4'($random(seed)), 4'($random(seed)),
                   4'($random(seed)), '0);
      if (b.ra == a.rt) b.ra = b.ra + 4'd1;   // keep lane 1 independent.
      if (b.rb == a.rt) b.rb = b.rb + 4'd1;
      run_bundle({a, b}, c);
    end
  endtask

  task automatic dependent_lanes();
    completion_t c;
    run_bundle({build_op(op_add, 4'd3, 4'd1, 4'd2, '0),
                build_op(op_sub, 4'd4, 4'd3, 4'd5, '0)}, c);
    compare_word("out_cmp.split through ra", data_w'(c.split), 1);
    run_bundle({build_op(op_xor, 4'd6, 4'd7, 4'd8, '0),
                build_op(op_sub, 4'd9, 4'd10, 4'd6, '0)}, c);
    compare_word("out_cmp.split through rb", data_w'(c.split), 1);
  endtask

  task automatic same_destination();
    logic [data_w-1:0] want_r5;
    completion_t       first;
    completion_t       c;
    want_r5 = ref_regs[3] ^ ref_regs[4];   // lane 1 result lands last.
    run_bundle({build_op(op_add, 4'd5, 4'd1, 4'd2, '0),
                build_op(op_xor, 4'd5, 4'd3, 4'd4, '0)}, first);
    run_bundle({build_op(op_or, 4'd11, 4'd5, 4'd5, '0),
                build_op(op_and, 4'd12, 4'd5, 4'd5, '0)}, c);
    compare_word("r5 after same-destination write", c.res0, want_r5);
  endtask

  task automatic union_decode();
    alu_op_t     a;
    completion_t c;
    run_bundle({build_op(op_xor, 4'd12, 4'd12, 4'd12, '0),
                build_op(op_xor, 4'd13, 4'd13, 4'd13, '0)}, c);
    run_bundle({build_op(op_addi, 4'd12, 4'd12, 4'd0, 16'hfffd),
                build_op(op_addi, 4'd13, 4'd13, 4'd0, 16'h8000)}, c);
    compare_word("r12 after addi -3", c.res0, 32'hffff_fffd);
    compare_word("r13 after addi -32768", c.res1, 32'hffff_8000);
    for (int j = 0; j < 12; j += 2) begin
      run_bundle({build_op(op_shift, 4'd14, 4'd12, 4'd0, shift_case(j)),
                  build_op(op_shift, 4'd15, 4'd13, 4'd0, shift_case(j + 1))}, c);
    end
    a = build_op(op_add, 4'd4, 4'd1, 4'd2, '0);
    run_bundle({a, build_op(op_addi, 4'd6, 4'd7, 4'd4, 16'h0007)}, c);
    compare_word("out_cmp.split under addi", data_w'(c.split), '0);
    run_bundle({a, build_op(op_shift, 4'd8, 4'd9, 4'd4, shift_case(4))}, c);
    compare_word("out_cmp.split under shift", data_w'(c.split), '0);
  endtask

  task automatic back_pressure();
    bundle_t     list [n_rand];
    int          ack_delay [n_rand];
    completion_t c;
    for (int i = 0; i < n_rand; i++) begin
      list[i]      = {random_op(), random_op()};
      ack_delay[i] = $unsigned($random(seed)) % 8;
    end
    fork
      for (int i = 0; i < n_rand; i++) send_bundle(list[i]);
      for (int k = 0; k < n_rand; k++) get_completion(ack_delay[k], c);
    join
    repeat (10) @(posedge clk);
    if (out_req || exp_q.size() != 0) abort_run("completion count wrong after back-pressure");
  endtask

  task automatic reset_reads_zero();
    completion_t c;
    apply_reset();
    compare_word("in_ack after reset", data_w'(in_ack), '0);
    compare_word("out_req after reset", data_w'(out_req), '0);
    run_bundle({build_op(op_add, 4'd1, 4'd3, 4'd7, '0),
                build_op(op_or, 4'd2, 4'd9, 4'd11, '0)}, c);
    compare_word("lane 0 result after reset", c.res0, '0);
    compare_word("lane 1 result after reset", c.res1, '0);
  endtask

  initial begin
    arst_n    = 1'b0;
    in_req    = 1'b0;
    in_bundle = '0;
    out_ack   = 1'b0;
    apply_reset();
    independent_lanes();
    dependent_lanes();
    same_destination();
    union_decode();
    back_pressure();
    reset_reads_zero();
    if (DUT.u_props.fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("bound assertions reported failures");
    end
  end

endmodule

//--- compile.f
hdl/alu_pkg.sv
hdl/issue_rx.sv
hdl/alu_regfile.sv
hdl/alu_exec.sv
hdl/wb_tx.sv
hdl/alu_cluster_top.sv
sim/alu_cluster_properties.sv
sim/tb_alu_cluster.sv

//--- Makefile
VERILATOR  := verilator
TOP        := tb_alu_cluster
FILELIST   := compile.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := TB FAILED
SOURCES    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST) --top-module $(TOP)

# a nonzero exit, such as a stop on a failed assertion, also fails the run.
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
